/* src/host_bridge_settings.svh */
`ifndef HOST_BRIDGE_SETTINGS_SVH
`define HOST_BRIDGE_SETTINGS_SVH

// ************************************************************************
// Host stream bridge sizing
// ************************************************************************

// Width of one stream word on every host and application port
`define HB_WORD_WIDTH 32

// Inbound and outbound FIFOs
// log2 of the depth, 4 gives 16 entries
`define HB_FIFO_ADDR_BITS 4

// Loopback FIFO
// Smaller than the others, 3 gives 8 entries
// When it fills up the application sees pc_msg_empty high
`define HB_LOOP_ADDR_BITS 3

`endif

/* src/host_bridge_pkg.sv */
`include "host_bridge_settings.svh"

// ************************************************************************
// Types shared by the bridge, its FIFOs and the end-of-file logic
// ************************************************************************

package host_bridge_pkg;

  // One word of the host write, read and loopback streams
  typedef logic [`HB_WORD_WIDTH-1:0] host_word_t;

  // Outbound FIFO entry
  // last marks the final message the application sends
  typedef struct packed {
    host_word_t data;
    logic       last;
  } outbound_entry_t;

  // End-of-input message from the host, all ones
  localparam host_word_t HB_TERMINATOR = '1;

endpackage

/* src/stream_fifo.sv */
`timescale 1ns/1ps

`include "host_bridge_settings.svh"

// ************************************************************************
// Synchronous first-word-fall-through FIFO
// ************************************************************************
// Head entry sits on dout whenever empty is low
// rd_en pops it, so the next entry shows up after the same edge

module stream_fifo
  import host_bridge_pkg::*;
#(
  parameter type payload_t = host_word_t,
  parameter int  ADDR_BITS = `HB_FIFO_ADDR_BITS
) (
  input  logic     bus_clk,
  input  logic     rst,
  input  logic     wr_en,
  input  payload_t din,
  input  logic     rd_en,
  output payload_t dout,
  output logic     full,
  output logic     empty
);

  // Occupancy at which full is raised
  localparam logic [ADDR_BITS:0] DEPTH = {1'b1, {ADDR_BITS{1'b0}}};

  payload_t mem [0:(2**ADDR_BITS)-1];

  logic [ADDR_BITS-1:0] wr_ptr;
  logic [ADDR_BITS-1:0] rd_ptr;
  logic [ADDR_BITS:0]   count;
  logic [ADDR_BITS:0]   count_next;
  logic                 push;
  logic                 pop;

  // Writes while full and reads while empty are dropped here
  assign push = wr_en & ~full;
  assign pop  = rd_en & ~empty;

  // ************************************************************************
  // Storage
  // ************************************************************************

  always_ff @(posedge bus_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Fall-through read port
  assign dout = mem[rd_ptr];

  // ************************************************************************
  // Pointers
  // ************************************************************************

  // Both wrap naturally at the power-of-two depth
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ************************************************************************
  // Occupancy and flags
  // ************************************************************************

  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // Flags registered with the count, no combinational path from wr_en/rd_en
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      count <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      count <= count_next;
      full  <= (count_next == DEPTH);
      empty <= (count_next == '0);
    end
  end

endmodule

/* src/stream_eof_tracker.sv */
`timescale 1ns/1ps

`include "host_bridge_settings.svh"

// ************************************************************************
// End-of-file flags for the host read and loopback streams
// ************************************************************************
// Two sticky bits, both cleared only by reset
//   term_seen    terminator message acknowledged by the application
//   last_popped  host has read the entry flagged as the final one

module stream_eof_tracker
  import host_bridge_pkg::*;
(
  input  logic       bus_clk,
  input  logic       rst,
  input  logic       msg_ack,
  input  host_word_t msg_data,
  input  logic       out_pop,
  input  logic       out_head_last,
  input  logic       out_empty,
  input  logic       wr_open,
  input  logic       loop_empty,
  output logic       rd_eof,
  output logic       loop_eof
);

  logic term_hit;
  logic last_hit;
  logic term_seen;
  logic last_popped;

  // msg_ack is expected to be qualified already, so it marks a real consume
  assign term_hit = msg_ack & (msg_data == HB_TERMINATOR);

  // Pop of the entry carrying the last flag
  assign last_hit = out_pop & out_head_last;

  // ************************************************************************
  // Sticky state
  // ************************************************************************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      term_seen <= 1'b0;
    end else if (term_hit) begin
      term_seen <= 1'b1;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      last_popped <= 1'b0;
    end else if (last_hit) begin
      last_popped <= 1'b1;
    end
  end

  // ************************************************************************
  // Flags
  // ************************************************************************

  // Read stream ends once the host drained everything after the terminator,
  // or right after the application's final entry went out
  assign rd_eof = (term_seen & out_empty) | last_popped;

  // Loopback ends when the write side is closed and nothing is left
  assign loop_eof = ~wr_open & loop_empty;

endmodule

/* src/host_bridge.sv */
`timescale 1ns/1ps

`include "host_bridge_settings.svh"

// ************************************************************************
// Host stream bridge
// ************************************************************************
// Host write  -> inbound FIFO  -> application (pc_msg)
// Application -> outbound FIFO -> host read (rd_data)
// Every acknowledged message is copied into the loopback FIFO

module host_bridge
  import host_bridge_pkg::*;
(
  input  logic       bus_clk,
  input  logic       rst,

  // Host write stream
  input  logic       wr_wren,
  input  host_word_t wr_data,
  input  logic       wr_open,
  output logic       wr_full,

  // Host read stream
  input  logic       rd_rden,
  input  logic       rd_open,
  output logic       rd_empty,
  output host_word_t rd_data,
  output logic       rd_eof,

  // Host loopback stream
  input  logic       loop_rden,
  output logic       loop_empty,
  output host_word_t loop_data,
  output logic       loop_eof,

  // Application receive side
  output host_word_t pc_msg,
  output logic       pc_msg_empty,
  input  logic       pc_msg_ack,

  // Application send side
  input  host_word_t fpga_msg,
  input  logic       fpga_msg_last,
  input  logic       fpga_msg_valid,
  output logic       fpga_msg_full
);

  logic            in_empty;
  logic            loop_full;
  logic            msg_ack;
  logic            out_wr;
  logic            out_pop;
  outbound_entry_t out_entry;
  outbound_entry_t out_head;

  // ************************************************************************
  // Inbound path and acknowledge gating
  // ************************************************************************

  // No message is offered while the loopback copy has nowhere to go
  assign pc_msg_empty = in_empty | loop_full;
  assign msg_ack      = pc_msg_ack & ~pc_msg_empty;

  stream_fifo #(
    .payload_t (host_word_t),
    .ADDR_BITS (`HB_FIFO_ADDR_BITS)
  ) u_inbound (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (wr_wren),
    .din     (wr_data),
    .rd_en   (msg_ack),
    .dout    (pc_msg),
    .full    (wr_full),
    .empty   (in_empty)
  );

  // Same head word that the application just consumed
  stream_fifo #(
    .payload_t (host_word_t),
    .ADDR_BITS (`HB_LOOP_ADDR_BITS)
  ) u_loopback (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (msg_ack),
    .din     (pc_msg),
    .rd_en   (loop_rden),
    .dout    (loop_data),
    .full    (loop_full),
    .empty   (loop_empty)
  );

  // ************************************************************************
  // Outbound path
  // ************************************************************************

  // Entries are discarded while the host has the read stream closed
  assign out_wr         = fpga_msg_valid & rd_open;
  assign out_entry.data = fpga_msg;
  assign out_entry.last = fpga_msg_last;

  stream_fifo #(
    .payload_t (outbound_entry_t),
    .ADDR_BITS (`HB_FIFO_ADDR_BITS)
  ) u_outbound (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (out_wr),
    .din     (out_entry),
    .rd_en   (rd_rden),
    .dout    (out_head),
    .full    (fpga_msg_full),
    .empty   (rd_empty)
  );

  assign rd_data = out_head.data;
  assign out_pop = rd_rden & ~rd_empty;

  // ************************************************************************
  // End-of-file generation
  // ************************************************************************

  stream_eof_tracker u_eof_tracker (
    .bus_clk       (bus_clk),
    .rst           (rst),
    .msg_ack       (msg_ack),
    .msg_data      (pc_msg),
    .out_pop       (out_pop),
    .out_head_last (out_head.last),
    .out_empty     (rd_empty),
    .wr_open       (wr_open),
    .loop_empty    (loop_empty),
    .rd_eof        (rd_eof),
    .loop_eof      (loop_eof)
  );

endmodule

/* test/bus_clock_gen.sv */
`timescale 1ns/1ps

// Free-running bus clock with a 100 ns period
// rst is held high for 16 rising edges at start and after each reset_req
module bus_clock_gen (
  input  logic reset_req,
  output logic bus_clk,
  output logic rst
);

  int unsigned hold;

  initial begin
    bus_clk = 1'b0;
    rst     = 1'b1;
    hold    = 15;
  end

  always #50 bus_clk = ~bus_clk;

  always @(posedge bus_clk) begin
    if (reset_req) begin
      rst  <= 1'b1;
      hold <= 15;
    end else if (hold != 0) begin
      hold <= hold - 1;
    end else begin
      rst <= 1'b0;
    end
  end

endmodule

/* test/host_bridge_sva.sv */
`timescale 1ns/1ps

`include "host_bridge_settings.svh"

// Concurrent checks on host_bridge internals
module host_bridge_sva (
  input logic bus_clk,
  input logic rst,
  input logic wr_full,
  input logic in_empty,
  input logic fpga_msg_full,
  input logic rd_empty,
  input logic loop_full,
  input logic loop_empty,
  input logic loop_rden,
  input logic pc_msg_empty,
  input logic pc_msg_ack,
  input logic out_pop,
  input logic out_head_last,
  input logic rd_eof
);

  localparam int LOOP_DEPTH = 1 << `HB_LOOP_ADDR_BITS;

  int   assert_failures = 0;
  int   loop_level;
  logic loop_push;
  logic loop_pop;
  logic last_seen;

  // Loopback traffic as seen on the top-level handshakes
  assign loop_push = pc_msg_ack && !pc_msg_empty;
  assign loop_pop  = loop_rden && !loop_empty;

  // Loopback occupancy counted independently of the FIFO flags
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      loop_level <= 0;
    end else if (loop_push && !loop_pop) begin
      loop_level <= loop_level + 1;
    end else if (loop_pop && !loop_push) begin
      loop_level <= loop_level - 1;
    end
  end

  // Set the cycle after the final entry leaves the outbound FIFO
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      last_seen <= 1'b0;
    end else if (out_pop && out_head_last) begin
      last_seen <= 1'b1;
    end
  end

  // ************************************************************************
  // FIFO flags
  // ************************************************************************

  inbound_flags: assert property (
    @(posedge bus_clk) disable iff (rst) !(wr_full && in_empty))
    else begin
      assert_failures++;
      $error("inbound FIFO full and empty together");
    end

  outbound_flags: assert property (
    @(posedge bus_clk) disable iff (rst) !(fpga_msg_full && rd_empty))
    else begin
      assert_failures++;
      $error("outbound FIFO full and empty together");
    end

  loopback_flags: assert property (
    @(posedge bus_clk) disable iff (rst) !(loop_full && loop_empty))
    else begin
      assert_failures++;
      $error("loopback FIFO full and empty together");
    end

  // Back-pressure and sticky end-of-file
  loop_blocks_msg: assert property (
    @(posedge bus_clk) disable iff (rst)
      (!loop_empty && loop_level == LOOP_DEPTH) |-> pc_msg_empty)
    else begin
      assert_failures++;
      $error("pc_msg offered while the loopback FIFO is full");
    end

  eof_sticky: assert property (@(posedge bus_clk) disable iff (rst) last_seen |-> rd_eof)
    else begin
      assert_failures++;
      $error("rd_eof dropped after the last entry was read");
    end

endmodule

/* test/host_bridge_tb.sv */
`timescale 1ns/1ps

`include "host_bridge_settings.svh"

module host_bridge_tb
  import host_bridge_pkg::*;
();

  localparam int IN_DEPTH   = 1 << `HB_FIFO_ADDR_BITS;
  localparam int LOOP_DEPTH = 1 << `HB_LOOP_ADDR_BITS;

  logic       bus_clk;
  logic       rst;
  logic       reset_req;

  // DUT ports, connected by name
  logic       wr_wren, wr_open, wr_full;
  logic       rd_rden, rd_open, rd_empty, rd_eof;
  logic       loop_rden, loop_empty, loop_eof;
  logic       pc_msg_empty, pc_msg_ack;
  logic       fpga_msg_last, fpga_msg_valid, fpga_msg_full;
  host_word_t wr_data, rd_data, loop_data, pc_msg, fpga_msg;

  // Values applied at the next rising edge
  logic       drv_wren, drv_wr_open, drv_rden, drv_rd_open, drv_loop_rden;
  logic       drv_ack, drv_last, drv_valid, drv_reset_req;
  host_word_t drv_wr_data, drv_fpga_msg;

  // Reference model of the three FIFOs and the sticky bits
  host_word_t      in_q[$];
  host_word_t      loop_q[$];
  outbound_entry_t out_q[$];
  logic            term_seen_m;
  logic            last_popped_m;
  logic [31:0]     rng_state;
  int              guard;

  bus_clock_gen u_clock_gen (
    .reset_req (reset_req),
    .bus_clk   (bus_clk),
    .rst       (rst)
  );

  host_bridge host_bridge_i (.*);

  bind host_bridge host_bridge_sva u_sva (.*, .out_head_last(out_head.last));

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Payload words never collide with the terminator
  function automatic host_word_t random_word();
    rng_state = xorshift32(rng_state);
    return (rng_state == HB_TERMINATOR) ? '0 : rng_state;
  endfunction

  function automatic logic chance(input int unsigned eighths);
    rng_state = xorshift32(rng_state);
    return rng_state[2:0] < eighths;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input host_word_t expected,
                            input host_word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %0t ns %s expected %h actual %h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %0t ns %s expected %b actual %b",
                          $time, name, expected, actual));
    end
  endtask

  // ************************************************************************
  // Model
  // ************************************************************************

  task automatic clear_model();
    in_q.delete();
    loop_q.delete();
    out_q.delete();
    term_seen_m   = 1'b0;
    last_popped_m = 1'b0;
  endtask

  task automatic compare_outputs();
    logic pc_empty_m;
    pc_empty_m = (in_q.size() == 0) || (loop_q.size() == LOOP_DEPTH);
    check_flag("wr_full", in_q.size() == IN_DEPTH, wr_full);
    check_flag("pc_msg_empty", pc_empty_m, pc_msg_empty);
    check_flag("loop_empty", loop_q.size() == 0, loop_empty);
    check_flag("rd_empty", out_q.size() == 0, rd_empty);
    check_flag("fpga_msg_full", out_q.size() == IN_DEPTH, fpga_msg_full);
    check_flag("rd_eof", (term_seen_m && out_q.size() == 0) || last_popped_m, rd_eof);
    check_flag("loop_eof", !wr_open && loop_q.size() == 0, loop_eof);
    if (!pc_empty_m) check_word("pc_msg", in_q[0], pc_msg);
    if (loop_q.size() != 0) check_word("loop_data", loop_q[0], loop_data);
    if (out_q.size() != 0) check_word("rd_data", out_q[0].data, rd_data);
  endtask

  // Inputs on the pins now are the ones the next edge consumes
  task automatic update_model();
    logic            ack;
    logic            loop_pop;
    logic            in_push;
    logic            out_push;
    logic            out_pop;
    outbound_entry_t entry;
    ack      = pc_msg_ack && in_q.size() != 0 && loop_q.size() != LOOP_DEPTH;
    loop_pop = loop_rden && loop_q.size() != 0;
    in_push  = wr_wren && in_q.size() != IN_DEPTH;
    out_push = fpga_msg_valid && rd_open && out_q.size() != IN_DEPTH;
    out_pop  = rd_rden && out_q.size() != 0;
    if (loop_pop) void'(loop_q.pop_front());
    if (ack) begin
      if (in_q[0] == HB_TERMINATOR) term_seen_m = 1'b1;
      loop_q.push_back(in_q.pop_front());
    end
    if (in_push) in_q.push_back(wr_data);
    if (out_pop) begin
      if (out_q[0].last) last_popped_m = 1'b1;
      void'(out_q.pop_front());
    end
    entry.data = fpga_msg;
    entry.last = fpga_msg_last;
    if (out_push) out_q.push_back(entry);
  endtask

  // ************************************************************************
  // Cycle driver
  // ************************************************************************

  task automatic tick();
    @(posedge bus_clk);
    wr_wren        <= drv_wren;
    wr_data        <= drv_wr_data;
    wr_open        <= drv_wr_open;
    rd_rden        <= drv_rden;
    rd_open        <= drv_rd_open;
    loop_rden      <= drv_loop_rden;
    pc_msg_ack     <= drv_ack;
    fpga_msg       <= drv_fpga_msg;
    fpga_msg_last  <= drv_last;
    fpga_msg_valid <= drv_valid;
    reset_req      <= drv_reset_req;
    @(negedge bus_clk);
    if (host_bridge_i.u_sva.assert_failures != 0) begin
      abort_run("A concurrent assertion on host_bridge failed");
    end
    if (rst) begin
      clear_model();
    end else begin
      compare_outputs();
      update_model();
    end
  endtask

  task automatic idle_inputs();
    drv_wren      = 1'b0;
    drv_ack       = 1'b0;
    drv_loop_rden = 1'b0;
    drv_valid     = 1'b0;
    drv_last      = 1'b0;
    drv_rden      = 1'b0;
    drv_wr_open   = 1'b1;
    drv_rd_open   = 1'b1;
    drv_reset_req = 1'b0;
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst) begin
      if (waited == 40) abort_run("Timeout waiting for rst to be released");
      tick();
      waited++;
    end
  endtask

  // Two ticks let the request reach the clock generator
  task automatic reset_dut();
    idle_inputs();
    drv_reset_req = 1'b1;
    tick();
    drv_reset_req = 1'b0;
    tick();
    wait_reset_release();
  endtask

  task automatic random_cycles(input int count);
    for (int i = 0; i < count; i++) begin
      drv_wren      = chance(5);
      drv_wr_data   = random_word();
      drv_ack       = chance(4);
      drv_loop_rden = chance(3);
      drv_valid     = chance(5);
      drv_fpga_msg  = random_word();
      drv_rden      = chance(3);
      drv_rd_open   = chance(6);
      drv_wr_open   = chance(6);
      tick();
    end
    idle_inputs();
  endtask

  initial begin
    rng_state    = 32'd90109;
    idle_inputs();
    drv_wr_data  = '0;
    drv_fpga_msg = '0;
    reset_req      = 1'b0;
    wr_wren        = 1'b0;
    wr_data        = '0;
    wr_open        = 1'b1;
    rd_rden        = 1'b0;
    rd_open        = 1'b1;
    loop_rden      = 1'b0;
    pc_msg_ack     = 1'b0;
    fpga_msg       = '0;
    fpga_msg_last  = 1'b0;
    fpga_msg_valid = 1'b0;
    tick();
    wait_reset_release();

    // Fill the inbound FIFO without acks, then one write that must be dropped
    guard = 0;
    while (!wr_full) begin
      if (guard == 40) abort_run("Timeout waiting for wr_full while filling the inbound FIFO");
      drv_wren    = 1'b1;
      drv_wr_data = random_word();
      tick();
      guard++;
    end
    drv_wr_data = random_word();
    tick();
    drv_wren = 1'b0;

    // Ack without draining loopback until it blocks the application
    drv_ack = 1'b1;
    guard   = 0;
    while (!(pc_msg_empty && !loop_empty)) begin
      if (guard == 40) abort_run("Timeout waiting for the loopback FIFO to block pc_msg");
      tick();
      guard++;
    end
    repeat (4) tick();
    check_flag("pc_msg_empty", 1'b1, pc_msg_empty);
    idle_inputs();

    random_cycles(800);

    // ************************************************************************
    // Terminator and read end-of-file
    // ************************************************************************

    drv_ack       = 1'b1;
    drv_loop_rden = 1'b1;
    drv_rden      = 1'b1;
    guard         = 0;
    while (!(pc_msg_empty && loop_empty && rd_empty)) begin
      if (guard == 100) abort_run("Timeout draining the FIFOs before the terminator test");
      tick();
      guard++;
    end
    idle_inputs();
    repeat (5) begin
      drv_valid    = 1'b1;
      drv_fpga_msg = random_word();
      tick();
    end
    drv_valid   = 1'b0;
    drv_wren    = 1'b1;
    drv_wr_data = HB_TERMINATOR;
    tick();
    drv_wren = 1'b0;
    guard    = 0;
    while (pc_msg_empty) begin
      if (guard == 20) abort_run("Timeout waiting for the terminator on pc_msg");
      tick();
      guard++;
    end
    check_word("pc_msg", HB_TERMINATOR, pc_msg);
    drv_ack = 1'b1;
    tick();
    drv_ack = 1'b0;
    tick();
    check_flag("rd_eof", 1'b0, rd_eof);
    drv_rden = 1'b1;
    guard    = 0;
    while (!rd_empty) begin
      if (guard == 40) abort_run("Timeout draining the outbound FIFO after the terminator");
      tick();
      guard++;
    end
    check_flag("rd_eof", 1'b1, rd_eof);

    // Last flag after a fresh reset
    reset_dut();
    drv_valid    = 1'b1;
    drv_last     = 1'b1;
    drv_fpga_msg = random_word();
    tick();
    drv_valid = 1'b0;
    drv_last  = 1'b0;
    guard     = 0;
    while (rd_empty) begin
      if (guard == 20) abort_run("Timeout waiting for the last entry on rd_data");
      tick();
      guard++;
    end
    check_flag("rd_eof", 1'b0, rd_eof);
    drv_rden = 1'b1;
    tick();
    drv_rden = 1'b0;
    tick();
    check_flag("rd_eof", 1'b1, rd_eof);
    random_cycles(200);
    check_flag("rd_eof", 1'b1, rd_eof);

    if (host_bridge_i.u_sva.assert_failures == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run("A concurrent assertion on host_bridge failed");
    end
  end

endmodule

/* tb.f */
+incdir+src
src/host_bridge_pkg.sv
src/stream_fifo.sv
src/stream_eof_tracker.sv
src/host_bridge.sv
test/bus_clock_gen.sv
test/host_bridge_sva.sv
test/host_bridge_tb.sv
